// ==== design/block_assembler.sv ====
`default_nettype none

`include "sha256_config.svh"

module block_assembler (
  input  wire logic               sha256_clk,
  input  wire logic               bus_rstn,
  input  wire logic               clear_i,      // soft clear, drops a partial block
  input  wire logic               push_i,
  input  wire logic [`PUSH_W-1:0] push_word_i,
  input  wire logic               ready_i,      // core idle
  output logic                    start_o,
  output sha256_pkg::block_t      block_o,
  output logic                    empty_o,
  output logic                    full_o
);

  import sha256_pkg::*;

  logic [3:0] cnt_q;                // pushes taken, 0 .. PUSH_WORDS
  block_t     block_q;              // shifts up, oldest push ends in W0/W1
  logic       take;

  assign full_o  = (cnt_q == 4'(`PUSH_WORDS));
  assign empty_o = (cnt_q == '0);
  assign take    = push_i & ~full_o;            // pushes into a full buffer are lost
  assign start_o = full_o & ready_i;            // core latches block_o on this cycle
  assign block_o = block_q;

  // --------------------------------------------------
  // word count

  always_ff @(posedge sha256_clk) begin
    if (!bus_rstn || clear_i) begin
      cnt_q <= '0;
    end else if (start_o) begin
      cnt_q <= '0;                              // buffer released to the core
    end else if (take) begin
      cnt_q <= cnt_q + 4'd1;
    end
  end

  // payload shift, two words per push
  always_ff @(posedge sha256_clk) begin
    if (take) begin
      block_q <= {block_q[13:0], push_word_i};
    end
  end

endmodule

`default_nettype wire

// ==== design/bus_regs.sv ====
`default_nettype none

`include "sha256_config.svh"

module bus_regs (
  input  wire logic                 sha256_clk,
  input  wire logic                 bus_rstn,
  input  wire sha256_pkg::bus_req_t sys_req_i,
  output sha256_pkg::bus_rsp_t      sys_rsp_o,
  output logic                      push_o,         // one cycle per lsb write
  output logic [`PUSH_W-1:0]        push_word_o,    // {msb reg, lsb write data}
  output logic                      sha_clear_o,
  input  wire logic                 empty_i,
  input  wire logic                 full_i,
  input  wire logic                 ready_i,
  input  wire logic                 digest_valid_i,
  input  wire sha256_pkg::digest_t  digest_i,
  output logic                      activated_o
);

  import sha256_pkg::*;

  word_t              ctrl_q;         // global control word
  sha256_ctrl_u       sha_ctrl_q;     // sha-256 control as raw word and fields
  word_t              push_msb_q;     // upper half of the next push
  digest_t            hash_q;         // [0] = H7 at the base address
  logic               valid_d_q;      // digest_valid_i delayed for edge detect
  logic               sha_on;
  glb_status_t        glb_st;
  sha_status_t        sha_st;
  word_t              glb_word;
  word_t              sha_word;
  logic [`ADDR_W-1:0] hash_off;       // offset into the hash window
  logic               hash_hit;

  // --------------------------------------------------
  // control registers and push strobe

  always_ff @(posedge sha256_clk) begin
    if (!bus_rstn) begin
      ctrl_q         <= '0;
      sha_ctrl_q.raw <= '0;
      push_o         <= 1'b0;
    end else begin
      sha_ctrl_q.f.reset <= 1'b0;     // one-shot pulse that a write below overrides
      push_o             <= 1'b0;
      if (sys_req_i.wen) begin
        case (sys_req_i.addr)
          `ADDR_CTRL:     ctrl_q         <= sys_req_i.wdata;
          `ADDR_SHA_CTRL: sha_ctrl_q.raw <= sys_req_i.wdata;
          `ADDR_PUSH_LSB: push_o         <= 1'b1;   // never stalls
          default:        ;
        endcase
      end
    end
  end

  // push payload
  always_ff @(posedge sha256_clk) begin
    if (sys_req_i.wen && sys_req_i.addr == `ADDR_PUSH_MSB) begin
      push_msb_q <= sys_req_i.wdata;
    end
    if (sys_req_i.wen && sys_req_i.addr == `ADDR_PUSH_LSB) begin
      push_word_o <= {push_msb_q, sys_req_i.wdata};
    end
  end

  assign sha_on      = sha_ctrl_q.f.enable & ctrl_q[`CTRL_ENABLE_BIT];
  assign sha_clear_o = ~sha_on | sha_ctrl_q.f.reset;   // held while disabled
  assign activated_o = ctrl_q[`CTRL_ENABLE_BIT];

  // --------------------------------------------------
  // hash capture on the rising edge of the core's valid level

  always_ff @(posedge sha256_clk) begin
    if (!bus_rstn || sha_clear_o) begin
      hash_q    <= '0;
      valid_d_q <= 1'b0;
    end else begin
      valid_d_q <= digest_valid_i;
      if (digest_valid_i && !valid_d_q) begin
        hash_q <= digest_i;           // same word order as the core
      end
    end
  end

  // --------------------------------------------------
  // status words

  assign glb_st.x11_on = ctrl_q[`CTRL_ENABLE_BIT];
  assign glb_st.sha_on = sha_on;

  assign sha_st.ready = ready_i;
  assign sha_st.valid = digest_valid_i;
  assign sha_st.empty = empty_i;
  assign sha_st.full  = full_i;       // software polls this before pushing

  always_comb begin
    glb_word                = '0;
    glb_word[`STAT_X11_ON]  = glb_st.x11_on;
    glb_word[`STAT_SHA_ON]  = glb_st.sha_on;
    sha_word                = '0;
    sha_word[`STAT_READY]   = sha_st.ready;
    sha_word[`STAT_VALID]   = sha_st.valid;
    sha_word[`STAT_EMPTY]   = sha_st.empty;
    sha_word[`STAT_FULL]    = sha_st.full;
  end

  // eight hash words at 0x110..0x12C on word addresses only
  assign hash_off = sys_req_i.addr - `ADDR_HASH_BASE;
  assign hash_hit = (hash_off[`ADDR_W-1:5] == '0) && (hash_off[1:0] == 2'b00);

  // --------------------------------------------------
  // read mux and acknowledge

  always_ff @(posedge sha256_clk) begin
    if (!bus_rstn) begin
      sys_rsp_o <= '0;
    end else begin
      sys_rsp_o.ack   <= sys_req_i.wen | sys_req_i.ren;   // both get one ack
      sys_rsp_o.rdata <= '0;                              // writes and holes read 0
      if (sys_req_i.ren) begin
        case (sys_req_i.addr)
          `ADDR_CTRL:       sys_rsp_o.rdata <= ctrl_q;
          `ADDR_STATUS:     sys_rsp_o.rdata <= glb_word;
          `ADDR_VERSION:    sys_rsp_o.rdata <= `VERSION_DATE;
          `ADDR_SHA_CTRL:   sys_rsp_o.rdata <= sha_ctrl_q.raw;
          `ADDR_SHA_STATUS: sys_rsp_o.rdata <= sha_word;
          default: begin
            if (hash_hit) begin
              sys_rsp_o.rdata <= hash_q[hash_off[4:2]];
            end
          end
        endcase
      end
    end
  end

endmodule

`default_nettype wire

// ==== design/sha256_config.svh ====
`ifndef SHA256_CONFIG_SVH
`define SHA256_CONFIG_SVH

// --------------------------------------------------
// widths
`define ADDR_W          20              // decoded bus address bits
`define WORD_W          32              // register and sha-256 word
`define PUSH_W          64              // one message push, msb:lsb
`define PUSH_WORDS      8               // pushes per 512 bit block

// --------------------------------------------------
// register map
`define ADDR_CTRL       20'h00000       // global control
`define ADDR_STATUS     20'h00004       // global status
`define ADDR_VERSION    20'h0000C       // build version 0xYYMMDDss
`define ADDR_SHA_CTRL   20'h00100       // sha-256 control
`define ADDR_SHA_STATUS 20'h00104       // sha-256 status
`define ADDR_PUSH_MSB   20'h00108       // upper push word, latched only
`define ADDR_PUSH_LSB   20'h0010C       // lower push word, write pushes
`define ADDR_HASH_BASE  20'h00110       // H7 here, H0 at +0x1C

// --------------------------------------------------
// bit positions
`define CTRL_ENABLE_BIT 0               // global enable
`define STAT_X11_ON     0               // global status, block enabled
`define STAT_SHA_ON     4               // global status, hash engine running
`define STAT_READY      0               // sha status, core idle
`define STAT_VALID      1               // sha status, digest valid
`define STAT_EMPTY      4               // sha status, no words buffered
`define STAT_FULL       5               // sha status, block complete

`define VERSION_DATE    32'h16082902    // yy mm dd serial

`endif

// ==== design/sha256_core.sv ====
`default_nettype none

module sha256_core (
  input  wire logic                sha256_clk,
  input  wire logic                bus_rstn,
  input  wire logic                clear_i,       // back to the initial hash values
  input  wire logic                start_i,       // sampled only while idle
  input  wire sha256_pkg::block_t  block_i,
  output logic                     ready_o,
  output logic                     digest_valid_o,
  output sha256_pkg::digest_t      digest_o
);

  import sha256_pkg::*;

  localparam logic [1:0] ST_IDLE  = 2'd0;
  localparam logic [1:0] ST_ROUND = 2'd1;
  localparam logic [1:0] ST_ADD   = 2'd2;

  // H0 in the top word
  localparam digest_t H_INIT = {32'h6a09e667, 32'hbb67ae85, 32'h3c6ef372, 32'ha54ff53a,
                                32'h510e527f, 32'h9b05688c, 32'h1f83d9ab, 32'h5be0cd19};

  // --------------------------------------------------
  // round constants

  localparam word_t K [64] = '{
    32'h428a2f98, 32'h71374491, 32'hb5c0fbcf, 32'he9b5dba5,
    32'h3956c25b, 32'h59f111f1, 32'h923f82a4, 32'hab1c5ed5,
    32'hd807aa98, 32'h12835b01, 32'h243185be, 32'h550c7dc3,
    32'h72be5d74, 32'h80deb1fe, 32'h9bdc06a7, 32'hc19bf174,
    32'he49b69c1, 32'hefbe4786, 32'h0fc19dc6, 32'h240ca1cc,
    32'h2de92c6f, 32'h4a7484aa, 32'h5cb0a9dc, 32'h76f988da,
    32'h983e5152, 32'ha831c66d, 32'hb00327c8, 32'hbf597fc7,
    32'hc6e00bf3, 32'hd5a79147, 32'h06ca6351, 32'h14292967,
    32'h27b70a85, 32'h2e1b2138, 32'h4d2c6dfc, 32'h53380d13,
    32'h650a7354, 32'h766a0abb, 32'h81c2c92e, 32'h92722c85,
    32'ha2bfe8a1, 32'ha81a664b, 32'hc24b8b70, 32'hc76c51a3,
    32'hd192e819, 32'hd6990624, 32'hf40e3585, 32'h106aa070,
    32'h19a4c116, 32'h1e376c08, 32'h2748774c, 32'h34b0bcb5,
    32'h391c0cb3, 32'h4ed8aa4a, 32'h5b9cca4f, 32'h682e6ff3,
    32'h748f82ee, 32'h78a5636f, 32'h84c87814, 32'h8cc70208,
    32'h90befffa, 32'ha4506ceb, 32'hbef9a3f7, 32'hc67178f2
  };

  function automatic word_t rotr(input word_t x, input int unsigned n);
    return (x >> n) | (x << ($bits(word_t) - n));
  endfunction

  logic [1:0] state_q;
  logic [5:0] rnd_q;                // round index, wraps back to 0 after 63
  digest_t    hash_q;               // chained state across blocks
  digest_t    wv_q;                 // working vars, [7] = a ... [0] = h
  block_t     w_q;                  // rolling schedule, [15] = W(t)
  word_t      t1;
  word_t      t2;
  word_t      w_next;               // W(t+16)
  digest_t    wv_next;

  // --------------------------------------------------
  // one round of compression

  always_comb begin
    t1 = wv_q[0] + (rotr(wv_q[3], 6) ^ rotr(wv_q[3], 11) ^ rotr(wv_q[3], 25))
       + ((wv_q[3] & wv_q[2]) ^ (~wv_q[3] & wv_q[1]))      // ch(e, f, g)
       + K[rnd_q] + w_q[15];
    t2 = (rotr(wv_q[7], 2) ^ rotr(wv_q[7], 13) ^ rotr(wv_q[7], 22))
       + ((wv_q[7] & wv_q[6]) ^ (wv_q[7] & wv_q[5]) ^ (wv_q[6] & wv_q[5]));  // maj
    wv_next = {t1 + t2, wv_q[7], wv_q[6], wv_q[5],
               wv_q[4] + t1, wv_q[3], wv_q[2], wv_q[1]};
    // schedule runs ahead, the last 16 words it makes are never used
    w_next = w_q[15]
           + (rotr(w_q[14], 7) ^ rotr(w_q[14], 18) ^ (w_q[14] >> 3))
           + w_q[6]
           + (rotr(w_q[1], 17) ^ rotr(w_q[1], 19) ^ (w_q[1] >> 10));
  end

  // --------------------------------------------------
  // control FSM and chained state

  always_ff @(posedge sha256_clk) begin
    if (!bus_rstn || clear_i) begin
      state_q        <= ST_IDLE;
      rnd_q          <= '0;
      digest_valid_o <= 1'b0;
      hash_q         <= H_INIT;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (start_i) begin        // load cycle
            state_q        <= ST_ROUND;
            rnd_q          <= '0;
            digest_valid_o <= 1'b0;
          end
        end
        ST_ROUND: begin
          rnd_q <= rnd_q + 6'd1;
          if (rnd_q == 6'd63) begin
            state_q <= ST_ADD;
          end
        end
        ST_ADD: begin
          for (int i = 0; i < 8; i++) begin
            hash_q[i] <= hash_q[i] + wv_q[i];
          end
          digest_valid_o <= 1'b1;   // 66 cycles after start
          state_q        <= ST_IDLE;
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // datapath, no reset
  always_ff @(posedge sha256_clk) begin
    if (state_q == ST_IDLE && start_i) begin
      wv_q <= hash_q;
      w_q  <= block_i;
    end else if (state_q == ST_ROUND) begin
      wv_q <= wv_next;
      w_q  <= {w_q[14:0], w_next};
    end
  end

  assign ready_o  = (state_q == ST_IDLE);   // rises together with digest_valid_o
  assign digest_o = hash_q;

endmodule

`default_nettype wire

// ==== design/sha256_pkg.sv ====
`default_nettype none

`include "sha256_config.svh"

package sha256_pkg;

  // --------------------------------------------------
  // basic words

  typedef logic [`WORD_W-1:0] word_t;       // one sha-256 word

  typedef word_t [7:0]  digest_t;           // [7] = H0 ... [0] = H7
  typedef word_t [15:0] block_t;            // [15] = W0 ... [0] = W15

  // --------------------------------------------------
  // system bus

  typedef struct packed {
    logic [`ADDR_W-1:0] addr;               // byte address
    word_t              wdata;
    logic               wen;                // one-cycle write strobe
    logic               ren;                // one-cycle read strobe
  } bus_req_t;

  typedef struct packed {
    word_t              rdata;              // zero for writes
    logic               ack;                // exactly one cycle after the strobe
  } bus_rsp_t;

  // --------------------------------------------------
  // sha-256 control word
  // stored and read back raw, control logic looks at the fields

  typedef struct packed {
    logic [`WORD_W-3:0] rsvd;               // kept as written, no function
    logic               reset;              // one-shot, self clearing
    logic               enable;             // anded with the global enable
  } sha256_ctrl_fields_t;

  typedef union packed {
    word_t               raw;
    sha256_ctrl_fields_t f;
  } sha256_ctrl_u;

  // --------------------------------------------------
  // status flags, placed into the status words by bit position

  typedef struct packed {
    logic sha_on;                           // hash engine out of soft clear
    logic x11_on;                           // global enable
  } glb_status_t;

  typedef struct packed {
    logic full;                             // block buffer complete
    logic empty;                            // block buffer has no words
    logic valid;                            // digest level from the core
    logic ready;                            // core idle
  } sha_status_t;

endpackage

`default_nettype wire

// ==== design/sha256_regs.sv ====
`default_nettype none

`include "sha256_config.svh"

module sha256_regs (
  input  wire logic                 sha256_clk,
  input  wire logic                 bus_rstn,     // sync, active low
  input  wire sha256_pkg::bus_req_t sys_req_i,
  output sha256_pkg::bus_rsp_t      sys_rsp_o,
  output logic                      activated_o   // global enable is set
);

  import sha256_pkg::*;

  // --------------------------------------------------
  // internal wiring

  logic               push;                       // one-cycle push strobe
  logic [`PUSH_W-1:0] push_word;
  logic               sha_clear;                  // soft clear for the hash path
  logic               blk_start;
  block_t             blk;
  logic               blk_empty;
  logic               blk_full;
  logic               core_ready;
  logic               digest_valid;               // level, high while digest stands
  digest_t            digest;

  bus_regs i_bus_regs (
    .sha256_clk     ( sha256_clk   ),
    .bus_rstn       ( bus_rstn     ),
    .sys_req_i      ( sys_req_i    ),
    .sys_rsp_o      ( sys_rsp_o    ),
    .push_o         ( push         ),
    .push_word_o    ( push_word    ),
    .sha_clear_o    ( sha_clear    ),
    .empty_i        ( blk_empty    ),
    .full_i         ( blk_full     ),
    .ready_i        ( core_ready   ),
    .digest_valid_i ( digest_valid ),
    .digest_i       ( digest       ),
    .activated_o    ( activated_o  )
  );

  block_assembler i_block_assembler (
    .sha256_clk  ( sha256_clk ),
    .bus_rstn    ( bus_rstn   ),
    .clear_i     ( sha_clear  ),
    .push_i      ( push       ),
    .push_word_i ( push_word  ),
    .ready_i     ( core_ready ),
    .start_o     ( blk_start  ),  // also releases the buffer
    .block_o     ( blk        ),
    .empty_o     ( blk_empty  ),
    .full_o      ( blk_full   )
  );

  sha256_core i_sha256_core (
    .sha256_clk     ( sha256_clk   ),
    .bus_rstn       ( bus_rstn     ),
    .clear_i        ( sha_clear    ),
    .start_i        ( blk_start    ),
    .block_i        ( blk          ),
    .ready_o        ( core_ready   ),
    .digest_valid_o ( digest_valid ),
    .digest_o       ( digest       )
  );

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# build and run the testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_sha256_regs -Mdir obj_dir -f vlog.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/Vtb_sha256_regs)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "Everything OK"; then
  exit 0
fi
exit 1

// ==== verif/sha256_testdata.txt ====
# B  padded block, sixteen hex words W0 .. W15 over two lines
# H  expected digest H0 .. H7 after the blocks before it
# R  soft reset, pushes while disabled, then enable again
# message abc
B 61626380 00000000 00000000 00000000 00000000 00000000 00000000 00000000
  00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000018
H ba7816bf 8f01cfea 414140de 5dae2223 b00361a3 96177a9c b410ff61 f20015ad
R
# 448 bit message over two blocks
B 61626364 62636465 63646566 64656667 65666768 66676869 6768696a 68696a6b
  696a6b6c 6a6b6c6d 6b6c6d6e 6c6d6e6f 6d6e6f70 6e6f7071 80000000 00000000
H 85e655d6 417a1795 3363376a 624cde5c 76e09589 cac5f811 cc4b32c1 f20e533a
B 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
  00000000 00000000 00000000 00000000 00000000 00000000 00000000 000001c0
H 248d6a61 d20638b8 e5c02693 0c3e6039 a33ce459 64ff2167 f6ecedd4 19db06c1
R
# empty message
B 80000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
  00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
H e3b0c442 98fc1c14 9afbf4c8 996fb924 27ae41e4 649b934c a495991b 7852b855

// ==== verif/tb_sha256_regs.sv ====
`default_nettype none

`include "sha256_config.svh"

module tb_sha256_regs;

  import sha256_pkg::*;

  localparam int    RST_CYCLES = 8;
  localparam int    POLL_MAX   = 100;                 // status polls per block
  localparam string DATA_FILE  = "verif/sha256_testdata.txt";

  // expected status words built from the bit positions
  localparam word_t SHA_IDLE    = (32'd1 << `STAT_READY) | (32'd1 << `STAT_EMPTY);
  localparam word_t GLB_ON      = (32'd1 << `STAT_X11_ON) | (32'd1 << `STAT_SHA_ON);
  localparam word_t VALID_EMPTY = (32'd1 << `STAT_VALID) | (32'd1 << `STAT_EMPTY);

  logic        sha256_clk;
  logic        bus_rstn;
  bus_req_t    sys_req;
  bus_rsp_t    sys_rsp;
  logic        activated;

  int          errors      = 0;
  int          reads       = 0;
  int          cycles      = 0;
  int          cycle_limit = 1000;                  // raised once the data file is sized
  logic [31:0] lfsr_q      = 32'h4e23;
  word_t       blk_w [16];                          // W0 .. W15 of the current block
  word_t       exp_h [8];                           // H0 .. H7 expected

  sha256_regs i_sha256_regs (
    .sha256_clk  ( sha256_clk ),
    .bus_rstn    ( bus_rstn   ),
    .sys_req_i   ( sys_req    ),
    .sys_rsp_o   ( sys_rsp    ),
    .activated_o ( activated  )
  );

  // --------------------------------------------------
  // clock and run limit

  initial begin
    sha256_clk = 1'b0;
    forever #20 sha256_clk = ~sha256_clk;           // period 40
  end

  always @(posedge sha256_clk) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("Something failed");
      $finish;
    end
  end

  // --------------------------------------------------
  // helpers

  // galois lfsr for x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h80200003;
    end
    return s >> 1;
  endfunction

  function automatic logic [`ADDR_W-1:0] hash_addr(input int i);
    return `ADDR_HASH_BASE + 20'(28 - 4 * i);       // H0 at 0x12C down to H7 at 0x110
  endfunction

  function automatic int count_lines();
    int fd;
    int c;
    int n;
    n  = 0;
    fd = $fopen(DATA_FILE, "r");
    if (fd == 0) begin
      return 0;
    end
    c = $fgetc(fd);
    while (c != -1) begin
      if (c == 10) begin
        n++;
      end
      c = $fgetc(fd);
    end
    $fclose(fd);
    return n;
  endfunction

  task automatic mismatch(input string what, input word_t got, input word_t exp);
    errors++;
    $display("ERROR at %0t: %s is %08h, expected %08h", $time, what, got, exp);
  endtask

  task automatic idle_gap();
    logic [1:0] n;
    n[0]   = lfsr_q[0];                             // one step per bit taken
    lfsr_q = lfsr_step(lfsr_q);
    n[1]   = lfsr_q[0];
    lfsr_q = lfsr_step(lfsr_q);
    repeat (n) @(negedge sha256_clk);
  endtask

  // ack is due at the first falling edge after the strobe and lasts one cycle
  task automatic wait_ack(output word_t rdata);
    int n;
    n = 0;
    while (!sys_rsp.ack && n < 4) begin
      @(negedge sha256_clk);
      n++;
    end
    if (!sys_rsp.ack) begin
      $display("no bus acknowledge arrived at time %0t", $time);
      errors++;
    end else if (n != 0) begin
      $display("the bus acknowledge came %0d cycles late at time %0t", n, $time);
      errors++;
    end
    rdata = sys_rsp.rdata;                          // stable at the falling edge
    @(negedge sha256_clk);
    if (sys_rsp.ack) begin
      $display("the bus acknowledge stayed high over one cycle at time %0t", $time);
      errors++;
    end
  endtask

  task automatic bus_write(input logic [`ADDR_W-1:0] addr, input word_t data);
    word_t rd;
    idle_gap();
    @(negedge sha256_clk);
    sys_req.addr  = addr;
    sys_req.wdata = data;
    sys_req.wen   = 1'b1;
    @(negedge sha256_clk);
    sys_req.wen   = 1'b0;                           // one-cycle strobe
    wait_ack(rd);
    if (rd !== '0) begin
      mismatch("write response data", rd, '0);
    end
  endtask

  task automatic bus_read(input logic [`ADDR_W-1:0] addr, output word_t rdata);
    idle_gap();
    @(negedge sha256_clk);
    sys_req.addr = addr;
    sys_req.ren  = 1'b1;
    @(negedge sha256_clk);
    sys_req.ren  = 1'b0;
    wait_ack(rdata);
    reads++;
  endtask

  task automatic check_hash_regs(input string what);
    word_t rd;
    for (int i = 0; i < 8; i++) begin
      bus_read(hash_addr(i), rd);
      if (rd !== exp_h[i]) begin
        mismatch($sformatf("H%0d %s", i, what), rd, exp_h[i]);
      end
    end
  endtask

  // first push lands in W0 and W1
  task automatic push_block();
    for (int k = 0; k < 8; k++) begin
      bus_write(`ADDR_PUSH_MSB, blk_w[2 * k]);
      bus_write(`ADDR_PUSH_LSB, blk_w[2 * k + 1]);
    end
  endtask

  // valid with an empty buffer only once the pushed block is hashed
  task automatic wait_digest();
    word_t rd;
    int    polls;
    rd    = '0;
    polls = 0;
    while ((rd & VALID_EMPTY) != VALID_EMPTY && polls < POLL_MAX) begin
      bus_read(`ADDR_SHA_STATUS, rd);
      polls++;
    end
    if ((rd & VALID_EMPTY) != VALID_EMPTY) begin
      $display("the digest never became valid after %0d status polls", polls);
      errors++;
    end
  endtask

  // --------------------------------------------------
  // soft reset, then pushes while disabled, then enable again

  task automatic soft_reset();
    word_t rd;
    bus_write(`ADDR_SHA_CTRL, 32'h3);               // enable plus one-shot reset
    bus_read(`ADDR_SHA_CTRL, rd);
    if (rd !== 32'h1) begin
      mismatch("sha-256 control after the reset bit", rd, 32'h1);
    end
    for (int i = 0; i < 8; i++) begin
      exp_h[i] = '0;
    end
    check_hash_regs("after soft reset");
    bus_write(`ADDR_SHA_CTRL, 32'h0);
    for (int k = 0; k < 8; k++) begin
      bus_write(`ADDR_PUSH_MSB, 32'hdead0000 | 32'(k));
      bus_write(`ADDR_PUSH_LSB, 32'hbeef0000 | 32'(k));
    end
    bus_read(`ADDR_SHA_STATUS, rd);                 // ready and empty but never valid
    if (rd !== SHA_IDLE) begin
      mismatch("sha-256 status after pushes while disabled", rd, SHA_IDLE);
    end
    bus_write(`ADDR_SHA_CTRL, 32'h1);
  endtask

  // --------------------------------------------------
  // data file walk

  task automatic skip_line(input int fd);
    int c;
    c = $fgetc(fd);
    while (c != -1 && c != 10) begin
      c = $fgetc(fd);
    end
  endtask

  task automatic run_data_file();
    int         fd;
    int         code;
    logic       bad;
    logic [7:0] tag;
    bad = 1'b0;
    fd  = $fopen(DATA_FILE, "r");
    if (fd == 0) begin
      $display("cannot open the data file %s", DATA_FILE);
      errors++;
      return;
    end
    code = $fscanf(fd, "%s", tag);
    while (code == 1 && !bad) begin
      if (tag == "#") begin
        skip_line(fd);
      end else if (tag == "B") begin
        for (int k = 0; k < 16 && !bad; k++) begin
          if ($fscanf(fd, "%h", blk_w[k]) != 1) bad = 1'b1;
        end
        if (!bad) begin
          push_block();
          wait_digest();
        end
      end else if (tag == "H") begin
        for (int i = 0; i < 8 && !bad; i++) begin
          if ($fscanf(fd, "%h", exp_h[i]) != 1) bad = 1'b1;
        end
        if (!bad) check_hash_regs("digest");
      end else if (tag == "R") begin
        soft_reset();
      end else begin
        bad = 1'b1;
      end
      code = $fscanf(fd, "%s", tag);
    end
    if (bad) begin
      $display("the data file is malformed near a line tagged %c", tag);
      errors++;
    end
    $fclose(fd);
  endtask

  // --------------------------------------------------
  // main sequence

  initial begin
    word_t rd;
    sys_req     = '0;
    bus_rstn    = 1'b0;
    cycle_limit = 1000 + 200 * count_lines();
    repeat (RST_CYCLES) @(negedge sha256_clk);
    bus_rstn    = 1'b1;

    // reset defaults
    if (activated !== 1'b0) mismatch("activated_o after reset", {31'd0, activated}, '0);
    bus_read(`ADDR_CTRL, rd);
    if (rd !== '0) mismatch("global control after reset", rd, '0);
    bus_read(`ADDR_SHA_CTRL, rd);
    if (rd !== '0) mismatch("sha-256 control after reset", rd, '0);
    bus_read(`ADDR_VERSION, rd);
    if (rd !== 32'h16082902) mismatch("version", rd, 32'h16082902);
    bus_read(20'h00008, rd);                        // hole in the map
    if (rd !== '0) mismatch("unmapped read", rd, '0);
    for (int i = 0; i < 8; i++) begin
      exp_h[i] = '0;
    end
    check_hash_regs("after reset");

    // control and status
    bus_write(`ADDR_CTRL, 32'h1);
    bus_write(`ADDR_SHA_CTRL, 32'h1);
    bus_read(`ADDR_CTRL, rd);
    if (rd !== 32'h1) mismatch("global control", rd, 32'h1);
    bus_read(`ADDR_SHA_CTRL, rd);
    if (rd !== 32'h1) mismatch("sha-256 control", rd, 32'h1);
    bus_read(`ADDR_STATUS, rd);
    if (rd !== GLB_ON) mismatch("global status", rd, GLB_ON);
    bus_read(`ADDR_SHA_STATUS, rd);
    if (rd !== SHA_IDLE) mismatch("sha-256 status when idle", rd, SHA_IDLE);
    if (activated !== 1'b1) mismatch("activated_o when enabled", {31'd0, activated}, 32'h1);

    run_data_file();                                // blocks, digests and soft resets

    $display("%0d errors in a run with %0d bus reads", errors, reads);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+design
design/sha256_pkg.sv
design/bus_regs.sv
design/block_assembler.sv
design/sha256_core.sv
design/sha256_regs.sv
verif/tb_sha256_regs.sv
